/* Makefile */
# Verilator build for the reflex arc
TOP  = reflex_arc_tb
LIST = reflex_arc_top.f

.PHONY: lint sim clean

lint:
	verilator --lint-only -Wall --timing -f $(LIST) --top-module reflex_arc_top

# pass only if the log holds the pass line
sim:
	verilator --binary --timing --assert -f $(LIST) --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee sim.log
	grep -qx "TEST OK" sim.log

clean:
	rm -rf obj_dir sim.log

/* afferent/afferent_encoder.sv */
`default_nettype none

`include "reflex_cfg.svh"

module afferent_encoder
(
    input  wire                    ep50trig,
    input  wire                    reset_sim,
    // muscle length, unsigned
    input  wire [`RA_HALF_W-1:0]   i_len,
    // ending sensitivity from the bank
    input  wire [`RA_HALF_W-1:0]   i_sens,
    // one-cycle spike
    output logic                   o_spike
);

    import reflex_pkg::*;

    ////////////////////////////////////////////////////////////
    // phase accumulator
    ////////////////////////////////////////////////////////////
    logic [`RA_WORD_W-1:0] phase_q;
    logic [`RA_WORD_W-1:0] step;
    // one extra bit catches the wrap
    logic [`RA_WORD_W:0]   phase_sum;

    // rate ~ len * sens / 2^32 spikes per cycle
    assign step      = phase_step(i_len, i_sens);
    assign phase_sum = {1'b0, phase_q} + {1'b0, step};

    always_ff @(posedge ep50trig or posedge reset_sim)
    begin
        if (reset_sim)
        begin
            phase_q <= '0;
            o_spike <= 1'b0;
        end
        else
        begin
            // keep the remainder for the next period
            phase_q <= phase_sum[`RA_WORD_W-1:0];
            // carry out is the spike, one cycle late
            o_spike <= phase_sum[`RA_WORD_W];
        end
    end

endmodule

`default_nettype wire

/* common/reflex_cfg.svh */
`ifndef REFLEX_CFG_SVH
`define REFLEX_CFG_SVH

////////////////////////////////////////////////////////////
// widths
////////////////////////////////////////////////////////////
// parameter word, phase accumulator, membrane
`define RA_WORD_W 32
// length, sensitivity, gain, spike count
`define RA_HALF_W 16
// parameter selector
`define RA_SEL_W 2

////////////////////////////////////////////////////////////
// values after reset
////////////////////////////////////////////////////////////
`define RA_THRESH_DEFAULT 32'h0004_0000
// zero sensitivity keeps both afferents silent
`define RA_SENS_DEFAULT 16'h0000
`define RA_GAIN_DEFAULT 16'h0000

// membrane loses mem >> shift per cycle
`define RA_LEAK_SHIFT 4

// selector codes, code 3 unused
`define RA_SEL_SENS 2'd0
`define RA_SEL_GAIN 2'd1
`define RA_SEL_THRESH 2'd2

`endif

/* common/reflex_pkg.sv */
`default_nettype none

package reflex_pkg;

    `include "reflex_cfg.svh"

    // which parameter word a load strobe writes
    typedef enum logic [`RA_SEL_W-1:0]
    {
        SEL_SENS   = `RA_SEL_SENS,
        SEL_GAIN   = `RA_SEL_GAIN,
        SEL_THRESH = `RA_SEL_THRESH
    } param_sel_e;

    // one loaded word, read whole or as Ia/II halves
    typedef union packed
    {
        logic [`RA_WORD_W-1:0] raw;
        struct packed
        {
            // Ia ending
            logic [`RA_HALF_W-1:0] hi;
            // II ending
            logic [`RA_HALF_W-1:0] lo;
        } pair;
    } param_word_u;

    // phase step of one afferent, length times sensitivity
    function automatic logic [`RA_WORD_W-1:0] phase_step(
        input logic [`RA_HALF_W-1:0] len,
        input logic [`RA_HALF_W-1:0] sens
    );
        return len * sens;
    endfunction

    // charge lost by the membrane in one cycle
    function automatic logic [`RA_WORD_W-1:0] leak_of(input logic [`RA_WORD_W-1:0] mem);
        return mem >> `RA_LEAK_SHIFT;
    endfunction

endpackage

`default_nettype wire

/* motoneuron/motoneuron.sv */
`default_nettype none

`include "reflex_cfg.svh"

module motoneuron
(
    input  wire                    ep50trig,
    input  wire                    reset_sim,
    // afferent spike pulses
    input  wire                    i_ia_spike,
    input  wire                    i_ii_spike,
    // synaptic weights per ending
    input  wire [`RA_HALF_W-1:0]   i_ia_gain,
    input  wire [`RA_HALF_W-1:0]   i_ii_gain,
    input  wire [`RA_WORD_W-1:0]   i_threshold,
    output logic                   o_spike,
    // own spikes, wraps around
    output logic [`RA_HALF_W-1:0]  o_spike_count
);

    import reflex_pkg::*;

    ////////////////////////////////////////////////////////////
    // synaptic input
    ////////////////////////////////////////////////////////////
    logic [`RA_WORD_W-1:0] syn_ia;
    logic [`RA_WORD_W-1:0] syn_ii;

    // gain only passes while its spike is high
    assign syn_ia = i_ia_spike ? {{(`RA_WORD_W-`RA_HALF_W){1'b0}}, i_ia_gain} : '0;
    assign syn_ii = i_ii_spike ? {{(`RA_WORD_W-`RA_HALF_W){1'b0}}, i_ii_gain} : '0;

    ////////////////////////////////////////////////////////////
    // leaky membrane
    ////////////////////////////////////////////////////////////
    logic [`RA_WORD_W-1:0] mem_q;
    logic [`RA_WORD_W-1:0] mem_leaked;
    // extra bit, the sum may pass 2^32
    logic [`RA_WORD_W:0]   mem_next;
    logic                  fire;

    // leak never exceeds the membrane, no underflow
    assign mem_leaked = mem_q - leak_of(mem_q);
    assign mem_next   = {1'b0, mem_leaked} + {1'b0, syn_ia} + {1'b0, syn_ii};
    // at or above threshold
    assign fire       = (mem_next >= {1'b0, i_threshold});

    always_ff @(posedge ep50trig or posedge reset_sim)
    begin
        if (reset_sim)
        begin
            mem_q         <= '0;
            o_spike       <= 1'b0;
            o_spike_count <= '0;
        end
        else if (fire)
        begin
            // spike and restart from rest
            mem_q         <= '0;
            o_spike       <= 1'b1;
            o_spike_count <= o_spike_count + 1'b1;
        end
        else
        begin
            // below threshold, fits in the word
            mem_q   <= mem_next[`RA_WORD_W-1:0];
            o_spike <= 1'b0;
        end
    end

endmodule

`default_nettype wire

/* reflex_arc_top.f */
+incdir+common
common/reflex_pkg.sv
rtl/param_bank.sv
afferent/afferent_encoder.sv
motoneuron/motoneuron.sv
rtl/reflex_arc_top.sv
tb/reflex_arc_tb.sv

/* rtl/param_bank.sv */
`default_nettype none

`include "reflex_cfg.svh"

module param_bank
(
    input  wire                        ep50trig,
    input  wire                        reset_sim,
    // one-cycle load strobe from the host side
    input  wire                        i_load,
    input  reflex_pkg::param_sel_e     i_load_sel,
    input  reflex_pkg::param_word_u    i_load_data,
    output logic [`RA_HALF_W-1:0]      o_ia_sens,
    output logic [`RA_HALF_W-1:0]      o_ii_sens,
    output logic [`RA_HALF_W-1:0]      o_ia_gain,
    output logic [`RA_HALF_W-1:0]      o_ii_gain,
    output logic [`RA_WORD_W-1:0]      o_threshold
);

    import reflex_pkg::*;

    ////////////////////////////////////////////////////////////
    // parameter words
    ////////////////////////////////////////////////////////////
    // hi half feeds Ia, lo half feeds II
    param_word_u sens_q;
    param_word_u gain_q;
    // used whole
    param_word_u thresh_q;

    always_ff @(posedge ep50trig or posedge reset_sim)
    begin
        if (reset_sim)
        begin
            sens_q.pair.hi <= `RA_SENS_DEFAULT;
            sens_q.pair.lo <= `RA_SENS_DEFAULT;
            gain_q.pair.hi <= `RA_GAIN_DEFAULT;
            gain_q.pair.lo <= `RA_GAIN_DEFAULT;
            thresh_q.raw   <= `RA_THRESH_DEFAULT;
        end
        else if (i_load)
        begin
            // selector picks the word, unknown code dropped
            case (i_load_sel)
                SEL_SENS:   sens_q   <= i_load_data;
                SEL_GAIN:   gain_q   <= i_load_data;
                SEL_THRESH: thresh_q <= i_load_data;
                default:
                begin
                    // code 3, nothing written
                end
            endcase
        end
    end

    ////////////////////////////////////////////////////////////
    // split into the two endings
    ////////////////////////////////////////////////////////////
    assign o_ia_sens   = sens_q.pair.hi;
    assign o_ii_sens   = sens_q.pair.lo;
    assign o_ia_gain   = gain_q.pair.hi;
    assign o_ii_gain   = gain_q.pair.lo;
    assign o_threshold = thresh_q.raw;

endmodule

`default_nettype wire

/* rtl/reflex_arc_top.sv */
`default_nettype none

`include "reflex_cfg.svh"

module reflex_arc_top
(
    input  wire                    ep50trig,
    input  wire                    reset_sim,
    // parameter load port
    input  wire                    i_load,
    input  wire [`RA_SEL_W-1:0]    i_load_sel,
    input  wire [`RA_WORD_W-1:0]   i_load_data,
    // muscle length seen by both endings
    input  wire [`RA_HALF_W-1:0]   i_len,
    output wire                    o_ia_spike,
    output wire                    o_ii_spike,
    output wire                    o_mn_spike,
    output wire [`RA_HALF_W-1:0]   o_mn_count
);

    ////////////////////////////////////////////////////////////
    // parameter bank
    ////////////////////////////////////////////////////////////
    wire [`RA_HALF_W-1:0] ia_sens;
    wire [`RA_HALF_W-1:0] ii_sens;
    wire [`RA_HALF_W-1:0] ia_gain;
    wire [`RA_HALF_W-1:0] ii_gain;
    wire [`RA_WORD_W-1:0] threshold;

    param_bank param_bank_inst
    (
        .ep50trig    (ep50trig),
        .reset_sim   (reset_sim),
        .i_load      (i_load),
        // raw code to selector, code 3 ignored in the bank
        .i_load_sel  (reflex_pkg::param_sel_e'(i_load_sel)),
        .i_load_data (i_load_data),
        .o_ia_sens   (ia_sens),
        .o_ii_sens   (ii_sens),
        .o_ia_gain   (ia_gain),
        .o_ii_gain   (ii_gain),
        .o_threshold (threshold)
    );

    ////////////////////////////////////////////////////////////
    // afferent endings
    ////////////////////////////////////////////////////////////
    // primary ending
    afferent_encoder ia_afferent
    (
        .ep50trig  (ep50trig),
        .reset_sim (reset_sim),
        .i_len     (i_len),
        .i_sens    (ia_sens),
        .o_spike   (o_ia_spike)
    );

    // secondary ending, same length, own sensitivity
    afferent_encoder ii_afferent
    (
        .ep50trig  (ep50trig),
        .reset_sim (reset_sim),
        .i_len     (i_len),
        .i_sens    (ii_sens),
        .o_spike   (o_ii_spike)
    );

    ////////////////////////////////////////////////////////////
    // motoneuron
    ////////////////////////////////////////////////////////////
    motoneuron motoneuron_inst
    (
        .ep50trig      (ep50trig),
        .reset_sim     (reset_sim),
        .i_ia_spike    (o_ia_spike),
        .i_ii_spike    (o_ii_spike),
        .i_ia_gain     (ia_gain),
        .i_ii_gain     (ii_gain),
        .i_threshold   (threshold),
        .o_spike       (o_mn_spike),
        .o_spike_count (o_mn_count)
    );

endmodule

`default_nettype wire

/* tb/reflex_arc_tb.sv */
`default_nettype none

`include "reflex_cfg.svh"

module reflex_arc_tb;

    timeunit 1ns;
    timeprecision 1ps;

    // window lengths in cycles
    localparam int quiet_n    = 200;
    localparam int rate_n     = 4000;
    localparam int follow_n   = 3000;
    localparam int silent_n   = 1000;
    localparam int sparse_n   = 2000;
    localparam int window_sum = quiet_n + 2 * rate_n + follow_n + silent_n + 2 * sparse_n;
    localparam int clk_period = 20;

    logic                    ep50trig;
    logic                    reset_sim;
    logic                    i_load;
    logic [`RA_SEL_W-1:0]    i_load_sel;
    logic [`RA_WORD_W-1:0]   i_load_data;
    logic [`RA_HALF_W-1:0]   i_len;
    wire                     o_ia_spike;
    wire                     o_ii_spike;
    wire                     o_mn_spike;
    wire  [`RA_HALF_W-1:0]   o_mn_count;

    // check enables set by the stimulus
    logic quiet;
    logic follow_mode;
    logic silent_mode;
    logic rate_check;
    int unsigned win_ia;
    int unsigned win_ii;
    int unsigned exp_ia;
    int unsigned exp_ii;
    // free-running spike totals since reset
    int unsigned ia_total;
    int unsigned ii_total;
    logic [31:0] mn_total;
    int errors;
    int tests;
    logic [31:0] rng;

    reflex_arc_top reflex_arc_top_inst
    (
        .ep50trig    (ep50trig),
        .reset_sim   (reset_sim),
        .i_load      (i_load),
        .i_load_sel  (i_load_sel),
        .i_load_data (i_load_data),
        .i_len       (i_len),
        .o_ia_spike  (o_ia_spike),
        .o_ii_spike  (o_ii_spike),
        .o_mn_spike  (o_mn_spike),
        .o_mn_count  (o_mn_count)
    );

    initial
    begin
        ep50trig = 1'b0;
        forever
        begin
            #(clk_period / 2) ep50trig = ~ep50trig;
        end
    end

    always @(posedge ep50trig or posedge reset_sim)
    begin
        if (reset_sim)
        begin
            ia_total <= 0;
            ii_total <= 0;
            mn_total <= '0;
        end
        else
        begin
            if (o_ia_spike)
                ia_total <= ia_total + 1;
            if (o_ii_spike)
                ii_total <= ii_total + 1;
            if (o_mn_spike)
                mn_total <= mn_total + 1;
        end
    end

    ////////////////////////////////////////////////////////////
    // helpers
    ////////////////////////////////////////////////////////////
    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        return y ^ (y << 5);
    endfunction

    // expected spikes floor(n * len * sens / 2^32)
    function automatic int unsigned rate_floor(input int n, input logic [15:0] len,
                                               input logic [15:0] sens);
        logic [63:0] total;
        total = 64'(n) * 64'(len) * 64'(sens);
        return 32'(total >> 32);
    endfunction

    function automatic bit within_one(input int unsigned got, input int unsigned want);
        return (got <= want + 1) && (want <= got + 1);
    endfunction

    task automatic report_mismatch(input string name, input logic [63:0] got,
                                   input logic [63:0] want);
        $display("mismatch %s: got %h expected %h", name, got, want);
        errors++;
    endtask

    task automatic report_test(input string name, input int mark);
        tests++;
        $display("test %0d %s: %0d failed checks", tests, name, errors - mark);
    endtask

    // ends 2 ns after the n-th rising edge
    task automatic wait_cycles(input int n);
        repeat (n) @(posedge ep50trig);
        #2;
    endtask

    task automatic load_param(input logic [`RA_SEL_W-1:0] sel, input logic [31:0] data);
        i_load      = 1'b1;
        i_load_sel  = sel;
        i_load_data = data;
        wait_cycles(1);
        i_load      = 1'b0;
    endtask

    // count both afferents over n cycles and arm the rate check
    task automatic measure_rate(input int n, input logic [15:0] len,
                                input logic [15:0] ia_s, input logic [15:0] ii_s);
        int unsigned ia_start;
        int unsigned ii_start;
        ia_start = ia_total;
        ii_start = ii_total;
        wait_cycles(n);
        win_ia     = ia_total - ia_start;
        win_ii     = ii_total - ii_start;
        exp_ia     = rate_floor(n, len, ia_s);
        exp_ii     = rate_floor(n, len, ii_s);
        rate_check = 1'b1;
        wait_cycles(1);
        rate_check = 1'b0;
    endtask

    ////////////////////////////////////////////////////////////
    // checks
    ////////////////////////////////////////////////////////////
    // default parameters keep everything silent
    quiet_chk: assert property (@(posedge ep50trig)
        quiet |-> ({o_ia_spike, o_ii_spike, o_mn_spike, o_mn_count} == '0))
        else report_mismatch("{o_ia_spike,o_ii_spike,o_mn_spike,o_mn_count}",
            64'($sampled({o_ia_spike, o_ii_spike, o_mn_spike, o_mn_count})), 64'(0));
    // both endings within one of the phase rule
    rate_chk: assert property (@(posedge ep50trig)
        rate_check |-> (within_one(win_ia, exp_ia) && within_one(win_ii, exp_ii)))
        else report_mismatch("o_ia_spike/o_ii_spike counts",
            64'($sampled({win_ia, win_ii})), 64'($sampled({exp_ia, exp_ii})));
    // mn spike one cycle after each ia spike
    follow_chk: assert property (@(posedge ep50trig) disable iff (reset_sim)
        follow_mode |-> (o_mn_spike == $past(o_ia_spike)))
        else report_mismatch("o_mn_spike", 64'($sampled(o_mn_spike)), 64'($past(o_ia_spike)));
    silent_chk: assert property (@(posedge ep50trig)
        silent_mode |-> !o_mn_spike)
        else report_mismatch("o_mn_spike", 64'($sampled(o_mn_spike)), 64'(0));
    // count includes the spike shown this cycle
    count_chk: assert property (@(posedge ep50trig) disable iff (reset_sim)
        o_mn_count == 16'(mn_total[15:0] + 16'(o_mn_spike)))
        else report_mismatch("o_mn_count", 64'($sampled(o_mn_count)),
            64'($sampled(16'(mn_total[15:0] + 16'(o_mn_spike)))));

    ////////////////////////////////////////////////////////////
    // stimulus
    ////////////////////////////////////////////////////////////
    initial
    begin
        int mark;
        logic [31:0] mn_start;
        logic [15:0] len_v;
        logic [15:0] sens_a;
        logic [15:0] sens_b;
        rng = 32'h93df_0d41;
        errors = 0;
        tests = 0;
        quiet = 1'b1;
        follow_mode = 1'b0;
        silent_mode = 1'b0;
        rate_check = 1'b0;
        win_ia = 0;
        win_ii = 0;
        exp_ia = 0;
        exp_ii = 0;
        reset_sim = 1'b1;
        i_load = 1'b0;
        i_load_sel = '0;
        i_load_data = '0;
        i_len = '0;
        repeat (3) @(posedge ep50trig);
        #2;
        reset_sim = 1'b0;

        // quiet after reset
        mark = errors;
        wait_cycles(quiet_n);
        quiet = 1'b0;
        report_test("reset quiet", mark);

        // Ia rate alone with the II half zero
        mark = errors;
        rng = xorshift32(rng);
        len_v = rng[15:0] | 16'h0100;
        sens_a = rng[31:16] | 16'h0100;
        i_len = len_v;
        load_param(`RA_SEL_SENS, {sens_a, 16'h0000});
        wait_cycles(3);
        measure_rate(rate_n, len_v, sens_a, 16'h0000);
        report_test("ia rate", mark);

        // each channel on its own rate
        mark = errors;
        rng = xorshift32(rng);
        len_v = rng[15:0] | 16'h0100;
        rng = xorshift32(rng);
        sens_a = rng[31:16] | 16'h0100;
        sens_b = rng[15:0] | 16'h0100;
        i_len = len_v;
        load_param(`RA_SEL_SENS, {sens_a, sens_b});
        wait_cycles(3);
        measure_rate(rate_n, len_v, sens_a, sens_b);
        report_test("ia and ii rates", mark);

        // Ia gain reaches a low threshold
        mark = errors;
        rng = xorshift32(rng);
        load_param(`RA_SEL_THRESH, 32'h0000_2000);
        load_param(`RA_SEL_GAIN, {16'h2000 | {3'b000, rng[12:0]}, 16'h0000});
        // zero word on code 3 would silence or flood the follow check
        load_param(2'd3, 32'h0000_0000);
        wait_cycles(3);
        mn_start = mn_total;
        follow_mode = 1'b1;
        wait_cycles(follow_n);
        follow_mode = 1'b0;
        if (mn_total == mn_start)
        begin
            $display("gain test produced no motoneuron spike");
            errors++;
        end
        // zero gains keep the mn silent
        load_param(`RA_SEL_GAIN, 32'h0000_0000);
        wait_cycles(2);
        silent_mode = 1'b1;
        wait_cycles(silent_n);
        report_test("gain follow and zero gain", mark);

        // threshold above both gains with sparse Ia spikes
        // lone spike decays before the next one
        mark = errors;
        rng = xorshift32(rng);
        len_v = 16'h3000 | {4'h0, rng[11:0]};
        i_len = len_v;
        load_param(`RA_SEL_THRESH, 32'h0001_0000);
        load_param(`RA_SEL_SENS, {16'h0400, 16'h0000});
        load_param(`RA_SEL_GAIN, {16'h4000 | {2'b00, rng[29:16]}, 16'h4000});
        wait_cycles(3);
        measure_rate(sparse_n, len_v, 16'h0400, 16'h0000);
        // code 3 into threshold or sensitivity would show here
        load_param(2'd3, 32'h0000_0001);
        wait_cycles(3);
        measure_rate(sparse_n, len_v, 16'h0400, 16'h0000);
        silent_mode = 1'b0;
        report_test("high threshold and code 3", mark);

        // count tracked over the whole run
        tests++;
        $display("test %0d mn count tracking: %0d spikes seen", tests, mn_total);
        $display("%0d tests run, %0d failed checks", tests, errors);
        if (errors == 0)
        begin
            $display("TEST OK");
        end
        else
        begin
            $display("TEST FAILED");
        end
        $finish;
    end

    // run limit of twice the sum of all windows
    initial
    begin
        #(2 * window_sum * clk_period);
        $display("watchdog expired after %0d cycles, run did not finish", 2 * window_sum);
        $display("TEST FAILED");
        $finish;
    end

endmodule

`default_nettype wire
